// File: source/eg_pkg.sv
package eg_pkg;

	// envelope attenuation, 0 loudest, 3ff silent
	typedef logic [9:0] level_t;

	// register rate as written by software
	typedef logic [4:0] rate_t;

	// effective rate after key scaling, 0..63
	typedef logic [5:0] eff_rate_t;

	typedef logic [4:0] kcode_t;

	// global envelope counter
	typedef logic [11:0] eg_cnt_t;

	// step weights 1, 2, 4, 8
	typedef logic [3:0] inc_t;

	typedef enum logic [1:0] {
		EG_ATTACK = 2'd0,
		EG_DECAY = 2'd1,
		EG_SUSTAIN = 2'd2,
		EG_RELEASE = 2'd3
	} eg_state_e;

	typedef struct packed {
		rate_t ar;
		rate_t d1r; // first decay
		rate_t d2r; // sustain decay
		logic [3:0] rr;
		logic [4:0] sl;
		logic [6:0] tl;
		logic [1:0] ks;
	} eg_patch_t;

	localparam level_t LEVEL_MAX = 10'h3ff;

endpackage

// File: source/eg_timer.sv
`timescale 1ns/1ps

module eg_timer
	import eg_pkg::*;
	#(
	parameter int EG_DIV = 3
	)
	(
	input logic mclk_i,
	input logic reset_i,
	input logic sample_tick_i,
	output logic eg_cycle_o,
	output eg_cnt_t eg_cnt_o
	);

	localparam int DIV_W = (EG_DIV > 1) ? $clog2(EG_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic div_last;
	eg_cnt_t eg_cnt_q;

	assign div_last = div_cnt == DIV_W'(EG_DIV - 1);
	assign eg_cycle_o = sample_tick_i & div_last; // same cycle as the tick

	always_ff @(posedge mclk_i)
	begin
		if (reset_i)
		begin
			div_cnt <= '0;
			eg_cnt_q <= '0;
		end
		else if (sample_tick_i)
		begin
			if (div_last)
			begin
				div_cnt <= '0;
				eg_cnt_q <= eg_cnt_q + 1'b1; // free running, wraps
			end
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	assign eg_cnt_o = eg_cnt_q;

endmodule

// File: source/eg_rate.sv
`timescale 1ns/1ps

module eg_rate
	import eg_pkg::*;
	(
	input eg_state_e state_i,
	input logic key_event_i,
	input logic eg_cycle_i,
	input eg_cnt_t eg_cnt_i,
	input kcode_t kcode_i,
	input eg_patch_t patch_i,
	output inc_t inc_o,
	output logic rate_max_o
	);

	rate_t base_rate;
	kcode_t ks_add;
	logic [6:0] rate_sum;
	eff_rate_t eff_rate;
	logic [3:0] rate_hi; // R / 4
	logic [1:0] rate_fine;
	logic [3:0] shift;
	eg_cnt_t low_mask;
	logic [14:0] cnt_shr;
	logic step_low;
	logic step_dbl;
	logic [1:0] hi_bit;

	// fine rate picks 0..3 slots out of four
	function automatic logic fine_sel(input logic [1:0] fine, input logic [1:0] sub);
		fine_sel = (~sub[0] & fine[1])
			| ((sub == 2'd0) & (fine == 2'd1))
			| ((sub == 2'd1) & (fine == 2'd3));
	endfunction

	always_comb
	begin
		if (key_event_i)
			base_rate = patch_i.ar; // attack rate from the key-on tick on
		else
		begin
			case (state_i)
				EG_ATTACK: base_rate = patch_i.ar;
				EG_DECAY: base_rate = patch_i.d1r;
				EG_SUSTAIN: base_rate = patch_i.d2r;
				default: base_rate = {patch_i.rr, 1'b1};
			endcase
		end
	end

	assign ks_add = kcode_i >> (2'd3 - patch_i.ks);
	assign rate_sum = {1'b0, base_rate, 1'b0} + {2'b00, ks_add};
	assign eff_rate = (base_rate == '0) ? '0 : (rate_sum[6] ? 6'd63 : rate_sum[5:0]);

	assign rate_hi = eff_rate[5:2];
	assign rate_fine = eff_rate[1:0];

	// slow rates, step period 2^shift envelope cycles
	assign shift = 4'd11 - rate_hi;
	assign low_mask = (12'd1 << shift) - 12'd1;
	assign cnt_shr = {3'b000, eg_cnt_i} >> shift;
	assign step_low = ((eg_cnt_i & low_mask) == '0)
		& (cnt_shr[0] | fine_sel(rate_fine, cnt_shr[2:1]));

	// fast rates, doubled weight on some cycles
	assign step_dbl = fine_sel(rate_fine, eg_cnt_i[1:0]);
	assign hi_bit = rate_hi[1:0] + {1'b0, step_dbl};

	always_comb
	begin
		inc_o = '0;
		if (eg_cycle_i && eff_rate != '0)
		begin
			if (rate_hi < 4'd12)
				inc_o = {3'b000, step_low};
			else if (rate_hi < 4'd15)
				inc_o[hi_bit] = 1'b1;
			else
				inc_o = 4'b1000;
		end
	end

	assign rate_max_o = eff_rate >= 6'd62;

endmodule

// File: source/eg_state_fsm.sv
`timescale 1ns/1ps

module eg_state_fsm
	import eg_pkg::*;
	(
	input logic mclk_i,
	input logic reset_i,
	input logic sample_tick_i,
	input logic key_on_i,
	input level_t level_i,
	input logic [4:0] sl_i,
	output eg_state_e state_o,
	output logic key_event_o,
	output logic phase_reset_o
	);

	eg_state_e state_q;
	eg_state_e state_d;
	logic key_prev;
	logic key_off;
	logic phase_reset_q;
	logic sl_reach;

	assign key_event_o = sample_tick_i & key_on_i & ~key_prev;
	assign key_off = sample_tick_i & ~key_on_i & key_prev;
	assign sl_reach = (level_i[9:5] == sl_i) & ~level_i[4];

	always_comb
	begin
		state_d = state_q;
		if (key_event_o)
			state_d = EG_ATTACK;
		else if (key_off)
			state_d = EG_RELEASE;
		else
		begin
			case (state_q)
				EG_ATTACK: if (level_i == '0) state_d = EG_DECAY;
				EG_DECAY: if (sl_reach) state_d = EG_SUSTAIN;
				default: state_d = state_q; // sustain and release hold
			endcase
		end
	end

	always_ff @(posedge mclk_i)
	begin
		if (reset_i)
		begin
			state_q <= EG_RELEASE;
			key_prev <= 1'b0;
		end
		else if (sample_tick_i)
		begin
			state_q <= state_d;
			key_prev <= key_on_i;
		end
	end

	// one cycle pulse after the key-on tick
	always_ff @(posedge mclk_i)
	begin
		if (reset_i)
			phase_reset_q <= 1'b0;
		else
			phase_reset_q <= key_event_o;
	end

	assign state_o = state_q;
	assign phase_reset_o = phase_reset_q;

endmodule

// File: source/eg_level.sv
`timescale 1ns/1ps

module eg_level
	import eg_pkg::*;
	(
	input logic mclk_i,
	input logic reset_i,
	input logic sample_tick_i,
	input eg_state_e state_i,
	input logic key_event_i,
	input logic rate_max_i,
	input inc_t inc_i,
	input logic [6:0] tl_i,
	output level_t level_o,
	output level_t eg_out_o
	);

	level_t level_q;
	level_t level_d;
	level_t eg_out_q;
	logic [11:0] att_dec;
	logic attack_mode;
	logic quiet;
	logic [10:0] out_sum;

	assign attack_mode = key_event_i | (state_i == EG_ATTACK);
	assign quiet = level_q[9:4] == 6'h3f;

	// exponential attack, larger steps while the level is high
	always_comb
	begin
		att_dec = '0;
		for (int k = 0; k < 4; k++)
		begin
			if (inc_i[k])
				att_dec = att_dec + {2'b00, level_q >> (4 - k)} + 12'd1;
		end
	end

	always_comb
	begin
		level_d = level_q;
		if (key_event_i && rate_max_i)
			level_d = '0; // instant attack
		else if (attack_mode)
		begin
			if (level_q != '0)
			begin
				if (att_dec >= {2'b00, level_q})
					level_d = '0;
				else
					level_d = level_q - att_dec[9:0];
			end
		end
		else if (quiet)
			level_d = LEVEL_MAX; // mute
		else
			level_d = level_q + level_t'(inc_i); // linear decay and release
	end

	always_ff @(posedge mclk_i)
	begin
		if (reset_i)
			level_q <= LEVEL_MAX;
		else if (sample_tick_i)
			level_q <= level_d;
	end

	// total level in steps of 8, clamp at silence
	assign out_sum = {1'b0, level_q} + {1'b0, tl_i, 3'b000};

	always_ff @(posedge mclk_i)
	begin
		if (reset_i)
			eg_out_q <= LEVEL_MAX;
		else
			eg_out_q <= out_sum[10] ? LEVEL_MAX : out_sum[9:0];
	end

	assign level_o = level_q;
	assign eg_out_o = eg_out_q;

endmodule

// File: source/eg_top.sv
`timescale 1ns/1ps

module eg_top
	import eg_pkg::*;
	#(
	parameter int EG_DIV = 3
	)
	(
	input logic mclk_i,
	input logic reset_i,
	input logic sample_tick_i,
	input logic key_on_i,
	input kcode_t kcode_i,
	input eg_patch_t patch_i,
	output level_t eg_out_o,
	output eg_state_e eg_state_o,
	output logic phase_reset_o
	);

	logic eg_cycle;
	eg_cnt_t eg_cnt;
	eg_state_e state;
	logic key_event;
	inc_t inc;
	logic rate_max;
	level_t level;

	eg_timer #(.EG_DIV(EG_DIV)) u_timer
		(
		.mclk_i(mclk_i),
		.reset_i(reset_i),
		.sample_tick_i(sample_tick_i),
		.eg_cycle_o(eg_cycle),
		.eg_cnt_o(eg_cnt)
		);

	eg_rate u_rate
		(
		.state_i(state),
		.key_event_i(key_event),
		.eg_cycle_i(eg_cycle),
		.eg_cnt_i(eg_cnt),
		.kcode_i(kcode_i),
		.patch_i(patch_i),
		.inc_o(inc),
		.rate_max_o(rate_max)
		);

	eg_state_fsm u_fsm
		(
		.mclk_i(mclk_i),
		.reset_i(reset_i),
		.sample_tick_i(sample_tick_i),
		.key_on_i(key_on_i),
		.level_i(level),
		.sl_i(patch_i.sl),
		.state_o(state),
		.key_event_o(key_event),
		.phase_reset_o(phase_reset_o)
		);

	eg_level u_level
		(
		.mclk_i(mclk_i),
		.reset_i(reset_i),
		.sample_tick_i(sample_tick_i),
		.state_i(state),
		.key_event_i(key_event),
		.rate_max_i(rate_max),
		.inc_i(inc),
		.tl_i(patch_i.tl),
		.level_o(level),
		.eg_out_o(eg_out_o)
		);

	assign eg_state_o = state;

endmodule

// File: sim/eg_chk.sv
`timescale 1ns/1ps

module eg_chk
	import eg_pkg::*;
	(
	input logic mclk_i,
	input logic reset_i,
	input logic sample_tick_i,
	input logic key_on_i,
	input eg_patch_t patch_i,
	input level_t eg_out_i,
	input eg_state_e eg_state_i,
	input logic phase_reset_i
	);

	int err_cnt; // polled by the testbench
	logic key_q;
	logic key_evt;
	logic fast_evt;

	initial err_cnt = 0;

	always_ff @(posedge mclk_i)
	begin
		if (reset_i)
			key_q <= 1'b0;
		else if (sample_tick_i)
			key_q <= key_on_i;
	end

	assign key_evt = sample_tick_i & key_on_i & ~key_q;
	assign fast_evt = key_evt & (patch_i.ar == 5'd31) & (patch_i.ks == 2'd3); // rate 62 or more

	a_reset: assert property (@(posedge mclk_i) $fell(reset_i)
		|-> eg_out_i == LEVEL_MAX && eg_state_i == EG_RELEASE && !phase_reset_i)
		else begin err_cnt++; $error("Fail eg_out_i %h after reset", $sampled(eg_out_i)); end

	a_key_on: assert property (@(posedge mclk_i) disable iff (reset_i)
		key_evt |=> phase_reset_i && eg_state_i == EG_ATTACK)
		else begin err_cnt++; $error("Fail eg_state_i %h after key-on", $sampled(eg_state_i)); end

	a_pulse: assert property (@(posedge mclk_i) disable iff (reset_i)
		phase_reset_i |-> $past(key_evt))
		else
		begin
			err_cnt++;
			$error("Fail phase_reset_i %h without key-on", $sampled(phase_reset_i));
		end

	a_pulse_len: assert property (@(posedge mclk_i) disable iff (reset_i)
		phase_reset_i |=> !phase_reset_i)
		else
		begin
			err_cnt++;
			$error("Fail phase_reset_i %h for two cycles", $sampled(phase_reset_i));
		end

	// instant attack, decay by the end of the next tick
	a_instant: assert property (@(posedge mclk_i) disable iff (reset_i)
		$past(fast_evt, 5) |-> eg_state_i == EG_DECAY)
		else begin err_cnt++; $error("Fail eg_state_i %h after instant attack", $sampled(eg_state_i)); end

	a_attack: assert property (@(posedge mclk_i) disable iff (reset_i)
		eg_state_i == EG_ATTACK && $past(eg_state_i) == EG_ATTACK
		&& $past(eg_state_i, 2) == EG_ATTACK |-> eg_out_i <= $past(eg_out_i))
		else begin err_cnt++; $error("Fail eg_out_i %h rose in attack", $sampled(eg_out_i)); end

	a_attack_end: assert property (@(posedge mclk_i) disable iff (reset_i)
		eg_state_i == EG_DECAY && $past(eg_state_i) == EG_ATTACK && patch_i.tl == '0
		|-> eg_out_i == '0)
		else begin err_cnt++; $error("Fail eg_out_i %h at decay start", $sampled(eg_out_i)); end

	a_decay: assert property (@(posedge mclk_i) disable iff (reset_i)
		eg_state_i == EG_DECAY && $past(eg_state_i) == EG_DECAY
		&& $past(eg_state_i, 2) == EG_DECAY |-> eg_out_i >= $past(eg_out_i))
		else begin err_cnt++; $error("Fail eg_out_i %h fell in decay", $sampled(eg_out_i)); end

	a_sustain_in: assert property (@(posedge mclk_i) disable iff (reset_i)
		eg_state_i == EG_SUSTAIN && $past(eg_state_i) == EG_DECAY && patch_i.tl == '0
		|-> eg_out_i >= {patch_i.sl, 5'b00000})
		else begin err_cnt++; $error("Fail eg_out_i %h below sl %h", $sampled(eg_out_i), patch_i.sl); end

	// zero rate holds the level
	a_sustain_hold: assert property (@(posedge mclk_i) disable iff (reset_i)
		eg_state_i == EG_SUSTAIN && $past(eg_state_i) == EG_SUSTAIN
		&& $past(eg_state_i, 2) == EG_SUSTAIN && patch_i.d2r == '0 |-> $stable(eg_out_i))
		else begin err_cnt++; $error("Fail eg_out_i %h moved in sustain", $sampled(eg_out_i)); end

	a_release: assert property (@(posedge mclk_i) disable iff (reset_i)
		eg_state_i == EG_RELEASE && $past(eg_state_i) == EG_RELEASE
		&& $past(eg_state_i, 2) == EG_RELEASE |-> eg_out_i >= $past(eg_out_i))
		else begin err_cnt++; $error("Fail eg_out_i %h fell in release", $sampled(eg_out_i)); end

	a_tl_floor: assert property (@(posedge mclk_i) disable iff (reset_i)
		patch_i.tl == $past(patch_i.tl) && eg_state_i == $past(eg_state_i)
		|-> eg_out_i >= {patch_i.tl, 3'b000})
		else begin err_cnt++; $error("Fail eg_out_i %h below tl %h", $sampled(eg_out_i), patch_i.tl); end

endmodule

// File: sim/eg_tb.sv
`timescale 1ns/1ps

module eg_tb
	import eg_pkg::*;
	();

	logic mclk = 1'b0;
	logic reset;
	logic sample_tick;
	logic key_on;
	kcode_t kcode;
	eg_patch_t patch;
	level_t eg_out;
	eg_state_e eg_state;
	logic phase_reset;
	logic [1:0] tick_phase;
	int seed;

	eg_top #(.EG_DIV(3)) u_dut
		(
		.mclk_i(mclk),
		.reset_i(reset),
		.sample_tick_i(sample_tick),
		.key_on_i(key_on),
		.kcode_i(kcode),
		.patch_i(patch),
		.eg_out_o(eg_out),
		.eg_state_o(eg_state),
		.phase_reset_o(phase_reset)
		);

	bind eg_top eg_chk u_chk
		(
		.mclk_i(mclk_i),
		.reset_i(reset_i),
		.sample_tick_i(sample_tick_i),
		.key_on_i(key_on_i),
		.patch_i(patch_i),
		.eg_out_i(eg_out_o),
		.eg_state_i(eg_state_o),
		.phase_reset_i(phase_reset_o)
		);

	always #2 mclk = ~mclk;

	always @(posedge mclk)
	begin
		#1;
		tick_phase = tick_phase + 2'd1;
		sample_tick = tick_phase == 2'd0; // one cycle in four
	end

	always @(posedge mclk)
	begin
		if (u_dut.u_chk.err_cnt != 0)
			fail_and_stop("an assertion in the checker failed");
	end

	task automatic fail_and_stop(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic hold_cycles(input int n);
		repeat (n) @(posedge mclk);
		#1;
	endtask

	task automatic reach_state(input eg_state_e want, input int max_cycles);
		int n;
		n = 0;
		while (eg_state != want && n < max_cycles)
		begin
			hold_cycles(1);
			n++;
		end
		if (eg_state != want)
			fail_and_stop($sformatf("state %s not reached in time", want.name()));
	endtask

	task automatic reach_output(input level_t want, input int max_cycles);
		int n;
		n = 0;
		while (eg_out != want && n < max_cycles)
		begin
			hold_cycles(1);
			n++;
		end
		if (eg_out != want)
			fail_and_stop($sformatf("output did not reach %h in time", want));
	endtask

	// one key-on/key-off cycle, patch changes only while silent
	task automatic play_note(input rate_t ar, input logic [1:0] ks, input logic [6:0] tl,
		input rate_t d2r);
		patch.ar = ar;
		patch.d1r = 5'd20;
		patch.d2r = d2r;
		patch.rr = 4'd12;
		patch.sl = 5'd4;
		patch.tl = tl;
		patch.ks = ks;
		kcode = kcode_t'($random(seed));
		hold_cycles(8);
		key_on = 1'b1;
		reach_state(EG_ATTACK, 16);
		reach_state(EG_DECAY, 20000);
		reach_state(EG_SUSTAIN, 40000);
		hold_cycles(200);
		key_on = 1'b0;
		reach_state(EG_RELEASE, 16);
		reach_output(LEVEL_MAX, 60000);
	endtask

	initial
	begin
		seed = 32'h242e;
		reset = 1'b1;
		sample_tick = 1'b0;
		tick_phase = 2'd0;
		key_on = 1'b0;
		kcode = '0;
		patch = '0;
		repeat (10) @(posedge mclk);
		#1;
		reset = 1'b0;
		hold_cycles(40); // idle at silence
		play_note(5'd31, 2'd3, 7'd0, 5'd0); // instant attack
		play_note(5'd20, 2'd0, 7'd0, 5'd0);
		play_note(5'd31, 2'd3, 7'h20, 5'd12); // total level offset
		hold_cycles(20);
		if (u_dut.u_chk.err_cnt != 0)
			fail_and_stop("an assertion in the checker failed");
		else
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// File: build.f
source/eg_pkg.sv
source/eg_timer.sv
source/eg_rate.sv
source/eg_state_fsm.sv
source/eg_level.sv
source/eg_top.sv
sim/eg_chk.sv
sim/eg_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the envelope generator testbench with Verilator.
# A failing check ends the simulation with $fatal and a nonzero exit status.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module eg_tb -o eg_sim
# assertion errors are counted by the checker, the testbench then stops the run
./obj_dir/eg_sim +verilator+error+limit+100
